// File: list.f
rtl/spi_reg_pkg.sv
rtl/spi_xfer_pkg.sv
rtl/spi_char_fifo.sv
rtl/spi_baud_gen.sv
rtl/spi_shifter.sv
rtl/spi_frame_ctrl.sv
rtl/spi_reg_file.sv
rtl/spi_master_top.sv
tb/tb_clk_gen.sv
tb/tb_spi_master.sv

// File: Makefile
TOP := tb_spi_master

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// File: tb/tb_spi_master.sv
`default_nettype none

module tb_spi_master
    import spi_reg_pkg::*, spi_xfer_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NCS      = 4;
    localparam int TX_DEPTH = 8;
    localparam int RX_DEPTH = 8;

    logic           S_SYSCLK;
    logic           S_RESETN;
    logic           reg_wr_i;
    logic           reg_rd_i;
    reg_addr_t      reg_addr_i;
    reg_word_t      reg_wdata_i;
    reg_word_t      reg_rdata_o;
    logic           irq_o;
    logic           spi_sck_o;
    logic           spi_mosi_o;
    logic           spi_miso_i;
    logic [NCS-1:0] spi_sel_o;

    int          mismatch_cnt = 0;
    int          fail_cnt     = 0;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 2000;
    int unsigned lcg_state    = 85;

    spi_char_t      tx_q[$];        // bytes accepted by the tx fifo
    spi_char_t      reply_q[$];     // slave replies not yet sent
    spi_char_t      reply_exp[$];
    spi_char_t      capt_q[$];      // bytes seen on mosi
    logic           exp_cpol = 1'b0;
    logic [NCS-1:0] exp_sel  = '1;

    logic [NCS-1:0] prev_sel  = '1;
    logic           prev_sck  = 1'b0;
    logic           half      = 1'b0;   // lead seen, trail pending
    int             bit_idx   = 0;
    spi_char_t      shift_in  = '0;
    spi_char_t      cur_reply = '0;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clk_gen (
        .clk_o(S_SYSCLK),
        .rst_n_o(S_RESETN)
    );

    spi_master_top #(.NCS(NCS), .TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) dut (
        .S_SYSCLK, .S_RESETN,
        .reg_wr_i, .reg_rd_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o, .irq_o,
        .spi_sck_o, .spi_mosi_o, .spi_miso_i, .spi_sel_o
    );

    function automatic int unsigned rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return (rand_word() >> 12) % n;
    endfunction

    function automatic spi_char_t next_reply();
        if (reply_q.size() == 0)
            return '0;
        return reply_q.pop_front();
    endfunction

    task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_char(input string name, input spi_char_t exp, input spi_char_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_sel(input string name, input logic [NCS-1:0] exp,
                             input logic [NCS-1:0] act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        fail_cnt++;
        $display("%s", what);
    endtask

    // slave device, reacts to sck and chip select edges
    always @(spi_sck_o or spi_sel_o) begin
        if (S_RESETN && spi_sel_o != prev_sel && spi_sel_o != '1) begin
            check_sel("chip select during frame", exp_sel, spi_sel_o);
            if (prev_sel == '1) begin
                bit_idx    = 0;
                half       = 1'b0;
                cur_reply  = next_reply();
                spi_miso_i <= cur_reply[7];
            end
        end
        if (S_RESETN && spi_sck_o != prev_sck && spi_sel_o != '1) begin
            if (spi_sck_o != exp_cpol) begin
                shift_in = {shift_in[6:0], spi_mosi_o};     // leading edge
                half     = 1'b1;
                if (bit_idx == 7)
                    capt_q.push_back(shift_in);
            end else if (half) begin
                half = 1'b0;
                if (bit_idx == 7) begin
                    bit_idx   = 0;
                    cur_reply = next_reply();
                end else begin
                    bit_idx++;
                end
                spi_miso_i <= cur_reply[7 - bit_idx];
            end
        end
        prev_sel = spi_sel_o;
        prev_sck = spi_sck_o;
    end

    always @(posedge S_SYSCLK) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            fail_cnt++;
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
            $display("Test failed");
            $finish;
        end
    end

    task automatic write_reg(input reg_addr_t addr, input reg_word_t data);
        @(posedge S_SYSCLK);
        reg_wr_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge S_SYSCLK);
        reg_wr_i <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output reg_word_t data);
        @(posedge S_SYSCLK);
        reg_rd_i   <= 1'b1;
        reg_addr_i <= addr;
        @(posedge S_SYSCLK);
        reg_rd_i <= 1'b0;
        @(negedge S_SYSCLK);    // data valid one cycle after the strobe
        data = reg_rdata_o;
    endtask

    task automatic expect_reg(input string name, input reg_addr_t addr, input reg_word_t exp);
        reg_word_t rd;
        read_reg(addr, rd);
        check_word(name, exp, rd);
    endtask

    task automatic settle();
        @(negedge S_SYSCLK);
    endtask

    task automatic wait_event(input int bit_pos, input logic val);
        reg_word_t rd;
        do begin
            read_reg(ADDR_SPIE, rd);
        end while (rd[bit_pos] !== val);
    endtask

    task automatic set_mode(input logic en, input logic loop);
        write_reg(ADDR_SPMODE, {30'b0, loop, en});
    endtask

    task automatic clear_done();
        write_reg(ADDR_SPIE, 32'h1);
    endtask

    task automatic push_tx(input int n, input bit accept);
        spi_char_t b;
        for (int i = 0; i < n; i++) begin
            b = spi_char_t'(rand_below(256));
            write_reg(ADDR_SPITF, {24'b0, b});
            if (accept)
                tx_q.push_back(b);
        end
    endtask

    task automatic start_frame(input int cs, input logic cpol, input int pm, input int n);
        spi_char_t r;
        write_reg(ADDR_CSMODE0 + reg_addr_t'(4 * cs),
                  (reg_word_t'(pm) << 4) | reg_word_t'(cpol));
        exp_cpol = cpol;
        exp_sel  = ~(NCS'(1) << cs);
        reply_q.delete();
        reply_exp.delete();
        capt_q.delete();
        for (int i = 0; i < n; i++) begin
            r = spi_char_t'(rand_below(256));
            reply_q.push_back(r);
            reply_exp.push_back(r);
        end
        cycle_limit += n * 16 * (pm + 1) + 100;
        write_reg(ADDR_SPCOM, (reg_word_t'(n - 1) << 8) | reg_word_t'(cs));
        while (spi_sel_o == '1) @(negedge S_SYSCLK);
        check_sel("chip select at frame start", exp_sel, spi_sel_o);
    endtask

    task automatic rand_frame(input int n);
        int   cs;
        int   pm;
        logic cpol;
        cs   = rand_below(NCS);
        cpol = logic'(rand_below(2));
        pm   = rand_below(16);
        start_frame(cs, cpol, pm, n);
    endtask

    task automatic finish_frame(input string name, input int n, input bit loop);
        spi_char_t sent[$];
        spi_char_t exp_rx[$];
        reg_word_t rd;
        wait_event(0, 1'b1);
        settle();
        check_sel({name, " sel released"}, '1, spi_sel_o);
        check_flag({name, " sck idle"}, exp_cpol, spi_sck_o);
        if (capt_q.size() != n)
            report_error($sformatf("%s: slave captured %0d characters, expected %0d",
                                   name, capt_q.size(), n));
        for (int i = 0; i < n; i++)
            sent.push_back(tx_q.pop_front());
        for (int i = 0; i < n && i < capt_q.size(); i++)
            check_char({name, " mosi data"}, sent[i], capt_q[i]);
        // rx fifo keeps the first RX_DEPTH characters only
        for (int i = 0; i < n && i < RX_DEPTH; i++)
            exp_rx.push_back(loop ? sent[i] : reply_exp[i]);
        foreach (exp_rx[i]) begin
            read_reg(ADDR_SPIRF, rd);
            check_word({name, " rx data"}, {24'b0, exp_rx[i]}, rd);
        end
        expect_reg({name, " rx empty read"}, ADDR_SPIRF, '0);
        expect_reg({name, " events"}, ADDR_SPIE, 32'h5);
    endtask

    task automatic run_frame(input string name, input bit loop);
        int n;
        n = 1 + rand_below(TX_DEPTH);
        set_mode(1'b1, loop);
        push_tx(n, 1'b1);
        rand_frame(n);
        finish_frame(name, n, loop);
        clear_done();
    endtask

    initial begin
        reg_word_t w;
        int        cs;
        int        n;
        reg_wr_i    <= 1'b0;
        reg_rd_i    <= 1'b0;
        reg_addr_i  <= '0;
        reg_wdata_i <= '0;
        spi_miso_i  <= 1'b0;
        @(posedge S_RESETN);
        @(posedge S_SYSCLK);

        expect_reg("mode after reset", ADDR_SPMODE, '0);
        for (int i = 0; i < NCS; i++)
            expect_reg("csmode after reset", ADDR_CSMODE0 + reg_addr_t'(4 * i), '0);
        check_sel("sel after reset", '1, spi_sel_o);
        check_flag("sck after reset", 1'b0, spi_sck_o);
        check_flag("irq after reset", 1'b0, irq_o);
        for (int i = 0; i < 4; i++) begin
            w = rand_word();
            write_reg(ADDR_SPIM, w);
            expect_reg("mask readback", ADDR_SPIM, w & 32'h7);
            cs = rand_below(NCS);
            w  = rand_word();
            write_reg(ADDR_CSMODE0 + reg_addr_t'(4 * cs), w);
            expect_reg("csmode readback", ADDR_CSMODE0 + reg_addr_t'(4 * cs), w & 32'hF1);
        end
        write_reg(ADDR_SPIM, '0);

        repeat (4) run_frame("normal transfer", 1'b0);
        repeat (2) run_frame("loop transfer", 1'b1);

        // done event and irq
        set_mode(1'b1, 1'b0);
        n = 1 + rand_below(TX_DEPTH);
        push_tx(n, 1'b1);
        rand_frame(n);
        finish_frame("done event", n, 1'b0);
        check_flag("irq with done masked", 1'b0, irq_o);
        write_reg(ADDR_SPIM, 32'h1);
        settle();
        check_flag("irq on done", 1'b1, irq_o);
        clear_done();
        settle();
        check_flag("irq after done clear", 1'b0, irq_o);
        expect_reg("done cleared", ADDR_SPIE, 32'h4);
        write_reg(ADDR_SPIM, '0);

        set_mode(1'b0, 1'b0);
        push_tx(TX_DEPTH + 2, 1'b0);   // disabled, all dropped
        expect_reg("tnf while disabled", ADDR_SPIE, 32'h4);
        run_frame("after disabled writes", 1'b0);

        set_mode(1'b1, 1'b0);
        push_tx(TX_DEPTH, 1'b1);
        expect_reg("tnf with full tx fifo", ADDR_SPIE, 32'h0);
        push_tx(1, 1'b0);
        rand_frame(TX_DEPTH);
        finish_frame("full tx fifo", TX_DEPTH, 1'b0);
        clear_done();

        // longer than the rx fifo, topped up as room appears
        n = RX_DEPTH + 2;
        push_tx(TX_DEPTH, 1'b1);
        rand_frame(n);
        for (int i = TX_DEPTH; i < n; i++) begin
            wait_event(2, 1'b1);
            push_tx(1, 1'b1);
        end
        finish_frame("rx overflow", n, 1'b0);
        clear_done();

        rand_frame(3);
        cycle_limit += 40;
        repeat (40) @(posedge S_SYSCLK);
        settle();
        check_flag("sck while waiting on data", exp_cpol, spi_sck_o);
        check_sel("sel while waiting on data", exp_sel, spi_sel_o);
        if (capt_q.size() != 0)
            report_error("characters went out before any tx data was written");
        push_tx(3, 1'b1);
        finish_frame("frame waiting on data", 3, 1'b0);
        clear_done();

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt + fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;    // release on a rising edge
    end

endmodule

`default_nettype wire

// File: rtl/spi_master_top.sv
`default_nettype none

module spi_master_top
    import spi_reg_pkg::*, spi_xfer_pkg::*;
#(
    parameter int NCS      = 4,
    parameter int TX_DEPTH = 8,
    parameter int RX_DEPTH = 8
) (
    input  wire              S_SYSCLK,
    input  wire              S_RESETN,
    input  logic             reg_wr_i,
    input  logic             reg_rd_i,
    input  reg_addr_t        reg_addr_i,
    input  reg_word_t        reg_wdata_i,
    output reg_word_t        reg_rdata_o,
    output logic             irq_o,
    output logic             spi_sck_o,
    output logic             spi_mosi_o,
    input  logic             spi_miso_i,
    output logic [NCS-1:0]   spi_sel_o
);

    spi_mode_t mode;
    cs_mode_t  csmode;
    spi_com_t  com;
    logic      frame_start, busy, frame_done;
    logic      tx_push, tx_pop, tx_empty, tx_full;
    logic      rx_pop, rx_valid, rx_empty;
    spi_char_t tx_wdata, tx_char, rx_char, rx_rdata;
    logic      run, lead, trail, char_go, char_done;

    spi_reg_file #(.NCS(NCS)) u_reg_file (
        .S_SYSCLK, .S_RESETN,
        .reg_wr_i, .reg_rd_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
        .mode_o(mode), .csmode_o(csmode), .com_o(com),
        .frame_start_o(frame_start), .busy_i(busy), .frame_done_i(frame_done),
        .tx_push_o(tx_push), .tx_data_o(tx_wdata), .tx_full_i(tx_full),
        .rx_pop_o(rx_pop), .rx_data_i(rx_rdata), .rx_empty_i(rx_empty),
        .irq_o
    );

    spi_frame_ctrl #(.NCS(NCS)) u_frame_ctrl (
        .S_SYSCLK, .S_RESETN,
        .mode_i(mode), .csmode_i(csmode), .com_i(com), .frame_start_i(frame_start),
        .busy_o(busy), .frame_done_o(frame_done),
        .tx_empty_i(tx_empty), .tx_pop_o(tx_pop), .run_o(run),
        .char_go_o(char_go), .char_done_i(char_done), .spi_sel_o
    );

    spi_char_fifo #(.DEPTH(TX_DEPTH)) tx_fifo (
        .S_SYSCLK, .S_RESETN,
        .push_i(tx_push), .din_i(tx_wdata), .pop_i(tx_pop), .dout_o(tx_char),
        .empty_o(tx_empty), .full_o(tx_full)
    );

    // overflow on rx is dropped inside the fifo
    spi_char_fifo #(.DEPTH(RX_DEPTH)) rx_fifo (
        .S_SYSCLK, .S_RESETN,
        .push_i(rx_valid), .din_i(rx_char), .pop_i(rx_pop), .dout_o(rx_rdata),
        .empty_o(rx_empty), .full_o()
    );

    spi_baud_gen u_baud_gen (
        .S_SYSCLK, .S_RESETN,
        .run_i(run), .cpol_i(csmode.cpol), .pm_i(csmode.pm),
        .sck_o(spi_sck_o), .lead_o(lead), .trail_o(trail)
    );

    spi_shifter u_shifter (
        .S_SYSCLK, .S_RESETN,
        .loop_i(mode.loop), .char_go_i(char_go), .tx_char_i(tx_char),
        .lead_i(lead), .trail_i(trail), .miso_i(spi_miso_i), .mosi_o(spi_mosi_o),
        .rx_char_o(rx_char), .rx_valid_o(rx_valid), .char_done_o(char_done)
    );

endmodule

`default_nettype wire

// File: rtl/spi_reg_file.sv
`default_nettype none

module spi_reg_file
    import spi_reg_pkg::*, spi_xfer_pkg::*;
#(
    parameter int NCS = 4
) (
    input  wire         S_SYSCLK,
    input  wire         S_RESETN,
    input  logic        reg_wr_i,
    input  logic        reg_rd_i,
    input  reg_addr_t   reg_addr_i,
    input  reg_word_t   reg_wdata_i,
    output reg_word_t   reg_rdata_o,
    output spi_mode_t   mode_o,
    output cs_mode_t    csmode_o,
    output spi_com_t    com_o,
    output logic        frame_start_o,
    input  logic        busy_i,
    input  logic        frame_done_i,
    output logic        tx_push_o,
    output spi_char_t   tx_data_o,
    input  logic        tx_full_i,
    output logic        rx_pop_o,
    input  spi_char_t   rx_data_i,
    input  logic        rx_empty_i,
    output logic        irq_o
);

    spi_mode_t   mode_q;
    spi_events_t mask_q;
    spi_com_t    com_q;
    cs_mode_t    csmode_q [NCS];
    logic        don_q;
    logic        frame_start_q;
    spi_events_t events;
    reg_word_t   csmode_rd;
    logic        cmd_ok;

    assign events = '{tnf: !tx_full_i, rne: !rx_empty_i, don: don_q};
    assign irq_o  = |(events & mask_q);

    assign mode_o        = mode_q;
    assign com_o         = com_q;
    assign csmode_o      = (com_q.cs < NCS) ? csmode_q[com_q.cs] : '0;
    assign frame_start_o = frame_start_q;

    // start_q still high means busy has not risen yet
    assign cmd_ok    = mode_q.en && !busy_i && !frame_start_q;
    assign tx_push_o = reg_wr_i && (reg_addr_i == ADDR_SPITF) && mode_q.en;
    assign tx_data_o = reg_wdata_i[7:0];
    assign rx_pop_o  = reg_rd_i && (reg_addr_i == ADDR_SPIRF) && !rx_empty_i;

    always_comb begin
        csmode_rd = '0;
        for (int i = 0; i < NCS; i++) begin
            if (reg_addr_i == ADDR_CSMODE0 + reg_addr_t'(CSMODE_STRIDE * i))
                csmode_rd = {24'b0, csmode_q[i].pm, 3'b0, csmode_q[i].cpol};
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            mode_q        <= '0;
            mask_q        <= '0;
            com_q         <= '0;
            don_q         <= 1'b0;
            frame_start_q <= 1'b0;
            for (int i = 0; i < NCS; i++) csmode_q[i] <= '0;
        end else begin
            frame_start_q <= 1'b0;
            if (reg_wr_i) begin
                case (reg_addr_i)
                    ADDR_SPMODE: mode_q <= reg_wdata_i[1:0];
                    ADDR_SPIE:   if (reg_wdata_i[0]) don_q <= 1'b0;
                    ADDR_SPIM:   mask_q <= reg_wdata_i[2:0];
                    ADDR_SPCOM: begin
                        if (cmd_ok) begin
                            com_q.cs      <= reg_wdata_i[1:0];
                            com_q.tranlen <= reg_wdata_i[COM_TRANLEN_LSB +: 8];
                            frame_start_q <= 1'b1;
                        end
                    end
                    default: ;
                endcase
                for (int i = 0; i < NCS; i++) begin
                    if (reg_addr_i == ADDR_CSMODE0 + reg_addr_t'(CSMODE_STRIDE * i)) begin
                        csmode_q[i].pm   <= reg_wdata_i[CSMODE_PM_LSB +: 4];
                        csmode_q[i].cpol <= reg_wdata_i[0];
                    end
                end
            end
            if (frame_done_i) don_q <= 1'b1;    // set wins over clear
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            reg_rdata_o <= '0;
        end else if (reg_rd_i) begin
            case (reg_addr_i)
                ADDR_SPMODE: reg_rdata_o <= {30'b0, mode_q};
                ADDR_SPIE:   reg_rdata_o <= {29'b0, events};
                ADDR_SPIM:   reg_rdata_o <= {29'b0, mask_q};
                ADDR_SPCOM:  reg_rdata_o <= {16'b0, com_q.tranlen, 6'b0, com_q.cs};
                ADDR_SPIRF:  reg_rdata_o <= rx_empty_i ? '0 : {24'b0, rx_data_i};
                default:     reg_rdata_o <= csmode_rd;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_frame_ctrl.sv
`default_nettype none

module spi_frame_ctrl
    import spi_reg_pkg::*, spi_xfer_pkg::*;
#(
    parameter int NCS = 4
) (
    input  wire              S_SYSCLK,
    input  wire              S_RESETN,
    input  spi_mode_t        mode_i,
    input  cs_mode_t         csmode_i,
    input  spi_com_t         com_i,
    input  logic             frame_start_i,
    output logic             busy_o,
    output logic             frame_done_o,
    input  logic             tx_empty_i,
    output logic             tx_pop_o,
    output logic             run_o,
    output logic             char_go_o,
    input  logic             char_done_i,
    output logic [NCS-1:0]   spi_sel_o
);

    frame_state_e   state;
    logic [7:0]     char_cnt;
    logic           last_char;
    logic           start_char;

    assign last_char  = (char_cnt == com_i.tranlen);
    assign start_char = (state == FRAME_DATA_WAIT) && !tx_empty_i;

    assign tx_pop_o     = start_char;
    assign char_go_o    = start_char;
    assign busy_o       = (state != FRAME_IDLE);
    assign run_o        = (state == FRAME_IN_TRANS);
    assign frame_done_o = (state == FRAME_IN_TRANS) && char_done_i && last_char;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state     <= FRAME_IDLE;
            char_cnt  <= '0;
            spi_sel_o <= '1;
        end else if (!mode_i.en) begin
            state     <= FRAME_IDLE;    // disable aborts the frame
            spi_sel_o <= '1;
        end else begin
            case (state)
                FRAME_IDLE: begin
                    if (frame_start_i) begin
                        state     <= FRAME_DATA_WAIT;
                        char_cnt  <= '0;
                        spi_sel_o <= ~(NCS'(1) << com_i.cs);
                    end
                end
                FRAME_DATA_WAIT: begin
                    if (!tx_empty_i) begin
                        state <= FRAME_IN_TRANS;
                    end
                end
                FRAME_IN_TRANS: begin
                    if (char_done_i) begin
                        if (last_char) begin
                            state     <= FRAME_IDLE;
                            spi_sel_o <= '1;
                        end else begin
                            state    <= FRAME_DATA_WAIT;
                            char_cnt <= char_cnt + 1'b1;
                        end
                    end
                end
                default: state <= FRAME_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_shifter.sv
`default_nettype none

module spi_shifter
    import spi_xfer_pkg::*;
(
    input  wire        S_SYSCLK,
    input  wire        S_RESETN,
    input  logic       loop_i,
    input  logic       char_go_i,
    input  spi_char_t  tx_char_i,
    input  logic       lead_i,
    input  logic       trail_i,
    input  logic       miso_i,
    output logic       mosi_o,
    output spi_char_t  rx_char_o,
    output logic       rx_valid_o,
    output logic       char_done_o
);

    spi_char_t  tx_sr;
    spi_char_t  rx_sr;
    logic [2:0] bit_cnt;
    logic       din;

    assign mosi_o = tx_sr[7];               // msb first
    assign din    = loop_i ? tx_sr[7] : miso_i;

    // eighth trailing edge closes the character
    assign char_done_o = trail_i && (bit_cnt == 3'd7);
    assign rx_valid_o  = char_done_o;
    assign rx_char_o   = rx_sr;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            tx_sr   <= '0;
            bit_cnt <= '0;
        end else if (char_go_i) begin
            tx_sr   <= tx_char_i;
            bit_cnt <= '0;
        end else if (trail_i) begin
            tx_sr   <= {tx_sr[6:0], 1'b0};
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (lead_i) rx_sr <= {rx_sr[6:0], din};    // sample on leading edge
    end

endmodule

`default_nettype wire

// File: rtl/spi_baud_gen.sv
`default_nettype none

module spi_baud_gen
    import spi_xfer_pkg::*;
(
    input  wire        S_SYSCLK,
    input  wire        S_RESETN,
    input  logic       run_i,
    input  logic       cpol_i,
    input  prescale_t  pm_i,
    output logic       sck_o,
    output logic       lead_o,
    output logic       trail_o
);

    prescale_t cnt;
    logic      tick;

    // sck toggles on the edge that ends a tick cycle
    assign tick    = run_i && (cnt == '0);
    assign lead_o  = tick && (sck_o == cpol_i);
    assign trail_o = tick && (sck_o != cpol_i);

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt   <= '0;
            sck_o <= 1'b0;
        end else if (!run_i) begin
            cnt   <= pm_i;          // park at idle level
            sck_o <= cpol_i;
        end else if (tick) begin
            cnt   <= pm_i;
            sck_o <= ~sck_o;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/spi_char_fifo.sv
`default_nettype none

module spi_char_fifo
    import spi_xfer_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  wire        S_SYSCLK,
    input  wire        S_RESETN,
    input  logic       push_i,
    input  spi_char_t  din_i,
    input  logic       pop_i,
    output spi_char_t  dout_o,
    output logic       empty_o,
    output logic       full_o
);

    localparam int AW = $clog2(DEPTH);

    spi_char_t      mem [DEPTH];
    logic [AW-1:0]  wr_ptr, rd_ptr;     // wrap on power of two depth
    logic [AW:0]    count;
    logic           do_push, do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign empty_o = (count == '0);
    assign full_o  = (count == (AW+1)'(DEPTH));
    assign dout_o  = mem[rd_ptr];

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) mem[wr_ptr] <= din_i;
    end

endmodule

`default_nettype wire

// File: rtl/spi_xfer_pkg.sv
`default_nettype none

package spi_xfer_pkg;

    typedef logic [7:0] spi_char_t;
    typedef logic [3:0] prescale_t;

    // frame sequencing
    typedef enum logic [1:0] {
        FRAME_IDLE,
        FRAME_DATA_WAIT,    // chip select low, waiting on tx data
        FRAME_IN_TRANS
    } frame_state_e;

endpackage

`default_nettype wire

// File: rtl/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_word_t;

    // register byte addresses
    localparam reg_addr_t ADDR_SPMODE  = 8'h00;
    localparam reg_addr_t ADDR_SPIE    = 8'h04;
    localparam reg_addr_t ADDR_SPIM    = 8'h08;
    localparam reg_addr_t ADDR_SPCOM   = 8'h0C;
    localparam reg_addr_t ADDR_SPITF   = 8'h10;
    localparam reg_addr_t ADDR_SPIRF   = 8'h14;
    localparam reg_addr_t ADDR_CSMODE0 = 8'h20;
    localparam int        CSMODE_STRIDE = 4;    // one slot per chip select

    // field offsets inside the 32-bit words
    localparam int CSMODE_PM_LSB   = 4;
    localparam int COM_TRANLEN_LSB = 8;

    typedef struct packed {
        logic loop;     // mosi fed back to receiver
        logic en;
    } spi_mode_t;

    typedef struct packed {
        logic [3:0] pm;
        logic       cpol;
    } cs_mode_t;

    typedef struct packed {
        logic [7:0] tranlen;    // chars minus one
        logic [1:0] cs;
    } spi_com_t;

    typedef struct packed {
        logic tnf;
        logic rne;
        logic don;      // sticky, write 1 to clear
    } spi_events_t;

endpackage

`default_nettype wire
